// File: filelist.f
common/axi_pkg.sv
common/mem_pkg.sv
interconnect/axi_interconnect.sv
rtl/axi_sram.sv
rtl/mem_subsystem_top.sv
verif/mem_subsystem_tb.sv

// File: verif/mem_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_tb
    import axi_pkg::*;
    import mem_pkg::*;
;

    localparam int MEM_BYTES = MEM_WORDS * 4;
    localparam int MAX_ENTRIES = 16;

    typedef enum logic [2:0] {OP_WRITE, OP_IREAD, OP_IPAIR, OP_BOTH, OP_PRIO} op_t;

    typedef struct packed
    {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_burst_t burst;
        axi_strb_t  strb;
        axi_resp_t  resp;
    } burst_rec_t;

    typedef struct packed
    {
        op_t        op;
        burst_rec_t req;
    } entry_t;

    logic       aclk = 1'b0;
    logic       aresetn;

    axi_id_t    inst_arid;
    axi_addr_t  inst_araddr;
    axi_len_t   inst_arlen;
    axi_burst_t inst_arburst;
    logic       inst_arvalid;
    logic       inst_arready;
    axi_id_t    inst_rid;
    axi_data_t  inst_rdata;
    axi_resp_t  inst_rresp;
    logic       inst_rlast;
    logic       inst_rvalid;
    logic       inst_rready;

    axi_id_t    data_arid;
    axi_addr_t  data_araddr;
    axi_len_t   data_arlen;
    axi_burst_t data_arburst;
    logic       data_arvalid;
    logic       data_arready;
    axi_id_t    data_rid;
    axi_data_t  data_rdata;
    axi_resp_t  data_rresp;
    logic       data_rlast;
    logic       data_rvalid;
    logic       data_rready;
    axi_id_t    data_awid;
    axi_addr_t  data_awaddr;
    axi_len_t   data_awlen;
    axi_burst_t data_awburst;
    logic       data_awvalid;
    logic       data_awready;
    axi_data_t  data_wdata;
    axi_strb_t  data_wstrb;
    logic       data_wlast;
    logic       data_wvalid;
    logic       data_wready;
    axi_id_t    data_bid;
    axi_resp_t  data_bresp;
    logic       data_bvalid;
    logic       data_bready;

    // stimulus table and reference model
    entry_t     tbl [MAX_ENTRIES];
    int         n_entries = 0;
    axi_data_t  ref_mem [MEM_WORDS];

    // per-entry read bookkeeping, index 0 is icache, 1 is dcache
    burst_rec_t rd_list [2][2];
    int         rd_n [2];
    int         ar_count [2];
    int         data_gate;
    axi_id_t    done_ids [4];
    int         done_n;

    int         cycle_count = 0;
    int         cycle_limit = 0;

    mem_subsystem_top mem_subsystem_top_inst (.*);

    always #4 aclk = ~aclk;

    always @(posedge aclk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("tests failed");
            $fatal(1, "no progress before the cycle limit");
        end
    end

    ////////////////////
    // checking helpers
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
            $display("tests failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic mem_word_addr_t beat_word_addr(input burst_rec_t b, input int beat);
        mem_word_addr_t wa;
        wa = b.addr[MEM_AW+1:2];
        if (b.burst == BURST_INCR)
            wa = wa + mem_word_addr_t'(beat);
        return wa;
    endfunction

    // out-of-range bursts read back as zero
    function automatic axi_data_t expected_word(input burst_rec_t b, input int beat);
        if (b.addr >= MEM_BYTES)
            return '0;
        return ref_mem[beat_word_addr(b, beat)];
    endfunction

    ////////////////////
    // bus drivers
    ////////////////////

    task automatic drive_ar(input int m, input burst_rec_t b, input logic valid);
        if (m == 0)
        begin
            inst_arid    = b.id;
            inst_araddr  = b.addr;
            inst_arlen   = b.len;
            inst_arburst = b.burst;
            inst_arvalid = valid;
        end
        else
        begin
            data_arid    = b.id;
            data_araddr  = b.addr;
            data_arlen   = b.len;
            data_arburst = b.burst;
            data_arvalid = valid;
        end
    endtask

    task automatic set_rready(input int m, input logic value);
        if (m == 0)
            inst_rready = value;
        else
            data_rready = value;
    endtask

    // dcache holds back until enough icache requests were accepted
    task automatic issue_reads(input int m);
        int k;
        if (m == 1)
            wait (ar_count[0] >= data_gate);
        for (k = 0; k < rd_n[m]; k++)
        begin
            @(negedge aclk);
            drive_ar(m, rd_list[m][k], 1'b1);
            @(posedge aclk);
            while (!(m == 1 ? data_arready : inst_arready))
                @(posedge aclk);
            ar_count[m] = ar_count[m] + 1;
        end
        @(negedge aclk);
        drive_ar(m, '0, 1'b0);
    endtask

    task automatic collect_reads(input int m);
        burst_rec_t b;
        int         k;
        int         beat;
        logic       held;
        axi_data_t  held_data;
        logic       held_last;
        logic       rv;
        logic       rdy;
        logic       rl;
        axi_data_t  rd;
        for (k = 0; k < rd_n[m]; k++)
        begin
            b = rd_list[m][k];
            beat = 0;
            held = 1'b0;
            while (beat <= int'(b.len))
            begin
                @(negedge aclk);
                // stall about one cycle in four
                set_rready(m, ($urandom % 4) != 0);
                @(posedge aclk);
                rv  = (m == 1) ? data_rvalid : inst_rvalid;
                rdy = (m == 1) ? data_rready : inst_rready;
                rl  = (m == 1) ? data_rlast : inst_rlast;
                rd  = (m == 1) ? data_rdata : inst_rdata;
                if (rv)
                begin
                    if (held)
                    begin
                        check_value("rdata (held)", rd, held_data);
                        check_value("rlast (held)", rl, held_last);
                    end
                    if (rdy)
                    begin
                        check_value("rid", (m == 1) ? data_rid : inst_rid, b.id);
                        check_value("rresp", (m == 1) ? data_rresp : inst_rresp, b.resp);
                        check_value("rdata", rd, expected_word(b, beat));
                        check_value("rlast", rl, beat == int'(b.len));
                        beat = beat + 1;
                        held = 1'b0;
                    end
                    else
                    begin
                        held = 1'b1;
                        held_data = rd;
                        held_last = rl;
                    end
                end
            end
            done_ids[done_n] = b.id;
            done_n = done_n + 1;
        end
        @(negedge aclk);
        set_rready(m, 1'b0);
    endtask

    task automatic write_burst(input burst_rec_t b);
        axi_data_t      wd;
        mem_word_addr_t wa;
        int             beat;
        int             lane;
        @(negedge aclk);
        data_awid    = b.id;
        data_awaddr  = b.addr;
        data_awlen   = b.len;
        data_awburst = b.burst;
        data_awvalid = 1'b1;
        @(posedge aclk);
        while (!data_awready)
            @(posedge aclk);
        for (beat = 0; beat <= int'(b.len); beat++)
        begin
            @(negedge aclk);
            data_awvalid = 1'b0;
            wd = $urandom;
            data_wdata  = wd;
            data_wstrb  = b.strb;
            data_wlast  = (beat == int'(b.len));
            data_wvalid = 1'b1;
            @(posedge aclk);
            while (!data_wready)
                @(posedge aclk);
            // same lane rule as the sram, nothing stored out of range
            if (b.addr < MEM_BYTES)
            begin
                wa = beat_word_addr(b, beat);
                for (lane = 0; lane < 4; lane++)
                begin
                    if (b.strb[lane])
                        ref_mem[wa][8*lane +: 8] = wd[8*lane +: 8];
                end
            end
        end
        @(negedge aclk);
        data_wvalid = 1'b0;
        data_wlast  = 1'b0;
        data_bready = 1'b1;
        @(posedge aclk);
        while (!data_bvalid)
            @(posedge aclk);
        check_value("bid", data_bid, b.id);
        check_value("bresp", data_bresp, b.resp);
        @(negedge aclk);
        data_bready = 1'b0;
    endtask

    ////////////////////
    // table and driver loop
    ////////////////////

    task automatic add_entry(input op_t op, input axi_id_t id, input axi_addr_t addr,
                             input axi_len_t len, input axi_burst_t burst,
                             input axi_strb_t strb, input axi_resp_t resp);
        tbl[n_entries].op        = op;
        tbl[n_entries].req.id    = id;
        tbl[n_entries].req.addr  = addr;
        tbl[n_entries].req.len   = len;
        tbl[n_entries].req.burst = burst;
        tbl[n_entries].req.strb  = strb;
        tbl[n_entries].req.resp  = resp;
        n_entries = n_entries + 1;
    endtask

    task automatic load_table;
        add_entry(OP_WRITE, 4'h1, 32'h0000_0040, 8'd3, BURST_INCR,  4'hF, RESP_OKAY);
        add_entry(OP_BOTH,  4'h2, 32'h0000_0040, 8'd3, BURST_INCR,  4'hF, RESP_OKAY);
        add_entry(OP_WRITE, 4'h3, 32'h0000_0044, 8'd0, BURST_INCR,  4'h5, RESP_OKAY);
        add_entry(OP_IREAD, 4'h4, 32'h0000_0040, 8'd3, BURST_INCR,  4'hF, RESP_OKAY);
        add_entry(OP_WRITE, 4'h5, 32'h0000_0100, 8'd2, BURST_FIXED, 4'hF, RESP_OKAY);
        add_entry(OP_IREAD, 4'h6, 32'h0000_0100, 8'd0, BURST_INCR,  4'hF, RESP_OKAY);
        add_entry(OP_IREAD, 4'h7, 32'h0000_0100, 8'd2, BURST_FIXED, 4'hF, RESP_OKAY);
        add_entry(OP_PRIO,  4'h8, 32'h0000_0040, 8'd3, BURST_INCR,  4'hF, RESP_OKAY);
        add_entry(OP_WRITE, 4'hB, 32'h0000_0200, 8'd7, BURST_INCR,  4'hF, RESP_OKAY);
        add_entry(OP_IREAD, 4'hC, 32'h0000_0200, 8'd7, BURST_INCR,  4'hF, RESP_OKAY);
        add_entry(OP_IPAIR, 4'hD, 32'h0000_0200, 8'd7, BURST_INCR,  4'hF, RESP_OKAY);
        add_entry(OP_IREAD, 4'h1, 32'h0000_0400, 8'd3, BURST_INCR,  4'hF, RESP_SLVERR);
        add_entry(OP_BOTH,  4'h5, 32'h0000_07F0, 8'd1, BURST_INCR,  4'hF, RESP_SLVERR);
        // aliases word 0x10, must not land in the array
        add_entry(OP_WRITE, 4'h2, 32'h0000_0440, 8'd1, BURST_INCR,  4'hF, RESP_SLVERR);
        add_entry(OP_IREAD, 4'h3, 32'h0000_0040, 8'd3, BURST_INCR,  4'hF, RESP_OKAY);
    endtask

    task automatic run_entry(input entry_t e);
        burst_rec_t b;
        int         k;
        b = e.req;
        if (e.op == OP_WRITE)
            write_burst(b);
        else
        begin
            rd_n[0] = 1;
            rd_n[1] = 0;
            ar_count[0] = 0;
            ar_count[1] = 0;
            data_gate = 0;
            done_n = 0;
            rd_list[0][0] = b;
            if (e.op == OP_IPAIR)
            begin
                rd_list[0][1] = b;
                rd_list[0][1].id = b.id + 4'd1;
                rd_n[0] = 2;
            end
            else if (e.op == OP_BOTH || e.op == OP_PRIO)
            begin
                rd_list[1][0] = b;
                rd_list[1][0].id = b.id + 4'd1;
                rd_n[1] = 1;
            end
            // second icache burst queued behind the waiting dcache burst
            if (e.op == OP_PRIO)
            begin
                rd_list[0][1] = b;
                rd_list[0][1].id = b.id + 4'd2;
                rd_n[0] = 2;
                data_gate = 1;
            end
            fork
                issue_reads(0);
                issue_reads(1);
                collect_reads(0);
                collect_reads(1);
            join
            // icache first, then dcache wins the next boundary
            for (k = 0; k < rd_n[0] + rd_n[1]; k++)
                check_value("rid order", done_ids[k], b.id + axi_id_t'(k));
        end
    endtask

    initial
    begin
        int e;
        void'($urandom(76750));
        aresetn = 1'b0;
        drive_ar(0, '0, 1'b0);
        drive_ar(1, '0, 1'b0);
        inst_rready  = 1'b0;
        data_rready  = 1'b0;
        data_awid    = '0;
        data_awaddr  = '0;
        data_awlen   = '0;
        data_awburst = BURST_INCR;
        data_awvalid = 1'b0;
        data_wdata   = '0;
        data_wstrb   = '0;
        data_wlast   = 1'b0;
        data_wvalid  = 1'b0;
        data_bready  = 1'b0;

        load_table();
        cycle_limit = 50;
        for (e = 0; e < n_entries; e++)
            cycle_limit = cycle_limit + (int'(tbl[e].req.len) + 4) * 4;

        repeat (8) @(negedge aclk);
        aresetn = 1'b1;

        for (e = 0; e < n_entries; e++)
            run_entry(tbl[e]);

        repeat (2) @(negedge aclk);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_top
    import axi_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,

    // instruction master
    input  wire axi_id_t    inst_arid,
    input  wire axi_addr_t  inst_araddr,
    input  wire axi_len_t   inst_arlen,
    input  wire axi_burst_t inst_arburst,
    input  wire             inst_arvalid,
    output wire             inst_arready,
    output wire axi_id_t    inst_rid,
    output wire axi_data_t  inst_rdata,
    output wire axi_resp_t  inst_rresp,
    output wire             inst_rlast,
    output wire             inst_rvalid,
    input  wire             inst_rready,

    // data master
    input  wire axi_id_t    data_arid,
    input  wire axi_addr_t  data_araddr,
    input  wire axi_len_t   data_arlen,
    input  wire axi_burst_t data_arburst,
    input  wire             data_arvalid,
    output wire             data_arready,
    output wire axi_id_t    data_rid,
    output wire axi_data_t  data_rdata,
    output wire axi_resp_t  data_rresp,
    output wire             data_rlast,
    output wire             data_rvalid,
    input  wire             data_rready,
    input  wire axi_id_t    data_awid,
    input  wire axi_addr_t  data_awaddr,
    input  wire axi_len_t   data_awlen,
    input  wire axi_burst_t data_awburst,
    input  wire             data_awvalid,
    output wire             data_awready,
    input  wire axi_data_t  data_wdata,
    input  wire axi_strb_t  data_wstrb,
    input  wire             data_wlast,
    input  wire             data_wvalid,
    output wire             data_wready,
    output wire axi_id_t    data_bid,
    output wire axi_resp_t  data_bresp,
    output wire             data_bvalid,
    input  wire             data_bready
);

    // memory-side channels between interconnect and sram
    wire axi_id_t    arid;
    wire axi_addr_t  araddr;
    wire axi_len_t   arlen;
    wire axi_burst_t arburst;
    wire             arvalid;
    wire             arready;
    wire axi_id_t    rid;
    wire axi_data_t  rdata;
    wire axi_resp_t  rresp;
    wire             rlast;
    wire             rvalid;
    wire             rready;
    wire axi_id_t    awid;
    wire axi_addr_t  awaddr;
    wire axi_len_t   awlen;
    wire axi_burst_t awburst;
    wire             awvalid;
    wire             awready;
    wire axi_data_t  wdata;
    wire axi_strb_t  wstrb;
    wire             wlast;
    wire             wvalid;
    wire             wready;
    wire axi_id_t    bid;
    wire axi_resp_t  bresp;
    wire             bvalid;
    wire             bready;

    // port names match the wires one to one
    axi_interconnect axi_interconnect_inst (.*);

    axi_sram axi_sram_inst (.*);

endmodule

`default_nettype wire

// File: rtl/axi_sram.sv
`timescale 1ns/1ns
`default_nettype none

module axi_sram
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  wire             aclk,
    input  wire             aresetn,

    input  wire axi_id_t    arid,
    input  wire axi_addr_t  araddr,
    input  wire axi_len_t   arlen,
    input  wire axi_burst_t arburst,
    input  wire             arvalid,
    output logic            arready,
    output axi_id_t         rid,
    output axi_data_t       rdata,
    output axi_resp_t       rresp,
    output logic            rlast,
    output logic            rvalid,
    input  wire             rready,

    input  wire axi_id_t    awid,
    input  wire axi_addr_t  awaddr,
    input  wire axi_len_t   awlen,
    input  wire axi_burst_t awburst,
    input  wire             awvalid,
    output logic            awready,
    input  wire axi_data_t  wdata,
    input  wire axi_strb_t  wstrb,
    input  wire             wlast,
    input  wire             wvalid,
    output logic            wready,
    output axi_id_t         bid,
    output axi_resp_t       bresp,
    output logic            bvalid,
    input  wire             bready
);

    localparam axi_addr_t MEM_BYTES = axi_addr_t'(MEM_WORDS * 4);

    axi_data_t mem [MEM_WORDS];

    sram_state_t    state;
    mem_word_addr_t addr_q;
    mem_word_addr_t addr_next;
    axi_id_t        id_q;
    axi_len_t       cnt_q;
    axi_burst_t     burst_q;
    logic           slv_err;

    logic ar_fire;
    logic aw_fire;
    logic r_fire;
    logic w_fire;
    logic w_done;

    ////////////////////
    // handshakes
    ////////////////////

    // read request wins when both arrive together
    assign arready = (state == IDLE);
    assign awready = (state == IDLE) && !arvalid;
    assign rvalid  = (state == READ);
    assign wready  = (state == WRITE);
    assign bvalid  = (state == RESP);

    assign ar_fire = arvalid && arready;
    assign aw_fire = awvalid && awready;
    assign r_fire  = rvalid && rready;
    assign w_fire  = wvalid && wready;

    // counter also closes the burst if wlast never shows up
    assign w_done = w_fire && (wlast || cnt_q == '0);

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:
                    if (ar_fire)
                        state <= READ;
                    else if (aw_fire)
                        state <= WRITE;
                READ:
                    if (r_fire && rlast)
                        state <= IDLE;
                WRITE:
                    if (w_done)
                        state <= RESP;
                RESP:
                    if (bready)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    ////////////////////
    // burst tracking
    ////////////////////

    always_comb
    begin
        case (burst_q)
            BURST_FIXED: addr_next = addr_q;
            BURST_INCR:  addr_next = addr_q + 1'b1;
            default:     addr_next = addr_q;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (ar_fire)
        begin
            id_q    <= arid;
            addr_q  <= araddr[MEM_AW+1:2];
            cnt_q   <= arlen;
            burst_q <= arburst;
            slv_err <= (araddr >= MEM_BYTES);
        end
        else if (aw_fire)
        begin
            id_q    <= awid;
            addr_q  <= awaddr[MEM_AW+1:2];
            cnt_q   <= awlen;
            burst_q <= awburst;
            slv_err <= (awaddr >= MEM_BYTES);
        end
        else if (r_fire || w_fire)
        begin
            addr_q <= addr_next;
            cnt_q  <= cnt_q - 1'b1;
        end
    end

    ////////////////////
    // word array
    ////////////////////

    // per-lane write, nothing stored for an out-of-range burst
    always_ff @(posedge aclk)
    begin
        if (w_fire && !slv_err)
        begin
            for (int b = 0; b < $bits(axi_strb_t); b++)
            begin
                if (wstrb[b])
                    mem[addr_q][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    assign rid   = id_q;
    assign rdata = slv_err ? '0 : mem[addr_q];
    assign rresp = slv_err ? RESP_SLVERR : RESP_OKAY;
    assign rlast = (cnt_q == '0);

    assign bid   = id_q;
    assign bresp = slv_err ? RESP_SLVERR : RESP_OKAY;

endmodule

`default_nettype wire

// File: interconnect/axi_interconnect.sv
`timescale 1ns/1ns
`default_nettype none

module axi_interconnect
    import axi_pkg::*;
(
    input  wire            aclk,
    input  wire            aresetn,

    // icache, read only
    input  wire axi_id_t    inst_arid,
    input  wire axi_addr_t  inst_araddr,
    input  wire axi_len_t   inst_arlen,
    input  wire axi_burst_t inst_arburst,
    input  wire             inst_arvalid,
    output logic            inst_arready,
    output axi_id_t         inst_rid,
    output axi_data_t       inst_rdata,
    output axi_resp_t       inst_rresp,
    output logic            inst_rlast,
    output logic            inst_rvalid,
    input  wire             inst_rready,

    // dcache
    input  wire axi_id_t    data_arid,
    input  wire axi_addr_t  data_araddr,
    input  wire axi_len_t   data_arlen,
    input  wire axi_burst_t data_arburst,
    input  wire             data_arvalid,
    output logic            data_arready,
    output axi_id_t         data_rid,
    output axi_data_t       data_rdata,
    output axi_resp_t       data_rresp,
    output logic            data_rlast,
    output logic            data_rvalid,
    input  wire             data_rready,
    input  wire axi_id_t    data_awid,
    input  wire axi_addr_t  data_awaddr,
    input  wire axi_len_t   data_awlen,
    input  wire axi_burst_t data_awburst,
    input  wire             data_awvalid,
    output logic            data_awready,
    input  wire axi_data_t  data_wdata,
    input  wire axi_strb_t  data_wstrb,
    input  wire             data_wlast,
    input  wire             data_wvalid,
    output logic            data_wready,
    output axi_id_t         data_bid,
    output axi_resp_t       data_bresp,
    output logic            data_bvalid,
    input  wire             data_bready,

    // shared port towards memory
    output axi_id_t         arid,
    output axi_addr_t       araddr,
    output axi_len_t        arlen,
    output axi_burst_t      arburst,
    output logic            arvalid,
    input  wire             arready,
    input  wire axi_id_t    rid,
    input  wire axi_data_t  rdata,
    input  wire axi_resp_t  rresp,
    input  wire             rlast,
    input  wire             rvalid,
    output logic            rready,
    output axi_id_t         awid,
    output axi_addr_t       awaddr,
    output axi_len_t        awlen,
    output axi_burst_t      awburst,
    output logic            awvalid,
    input  wire             awready,
    output axi_data_t       wdata,
    output axi_strb_t       wstrb,
    output logic            wlast,
    output logic            wvalid,
    input  wire             wready,
    input  wire axi_id_t    bid,
    input  wire axi_resp_t  bresp,
    input  wire             bvalid,
    output logic            bready
);

    ////////////////////
    // read owner
    ////////////////////

    typedef enum logic {OWN_INST, OWN_DATA} read_owner_t;

    read_owner_t read_owner;
    read_owner_t owner_next;
    logic        burst_end;

    assign burst_end = rvalid && rready && rlast;

    // dcache wins at a burst boundary, icache stays owner otherwise
    always_comb
    begin
        owner_next = read_owner;
        if (burst_end)
            owner_next = data_arvalid ? OWN_DATA : OWN_INST;
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
            read_owner <= OWN_INST;
        else
            read_owner <= owner_next;
    end

    // ar fields and read handshakes follow the owner
    always_comb
    begin
        if (read_owner == OWN_DATA)
        begin
            arid    = data_arid;
            araddr  = data_araddr;
            arlen   = data_arlen;
            arburst = data_arburst;
            arvalid = data_arvalid;
            rready  = data_rready;
        end
        else
        begin
            arid    = inst_arid;
            araddr  = inst_araddr;
            arlen   = inst_arlen;
            arburst = inst_arburst;
            arvalid = inst_arvalid;
            rready  = inst_rready;
        end
    end

    assign inst_arready = (read_owner == OWN_INST) && arready;
    assign data_arready = (read_owner == OWN_DATA) && arready;
    assign inst_rvalid  = (read_owner == OWN_INST) && rvalid;
    assign data_rvalid  = (read_owner == OWN_DATA) && rvalid;

    // r payload goes to both, only the owner sees rvalid
    assign inst_rid   = rid;
    assign inst_rdata = rdata;
    assign inst_rresp = rresp;
    assign inst_rlast = rlast;
    assign data_rid   = rid;
    assign data_rdata = rdata;
    assign data_rresp = rresp;
    assign data_rlast = rlast;

    ////////////////////
    // write path
    ////////////////////

    // icache never writes, so dcache has the write channels alone
    assign awid         = data_awid;
    assign awaddr       = data_awaddr;
    assign awlen        = data_awlen;
    assign awburst      = data_awburst;
    assign awvalid      = data_awvalid;
    assign data_awready = awready;

    assign wdata       = data_wdata;
    assign wstrb       = data_wstrb;
    assign wlast       = data_wlast;
    assign wvalid      = data_wvalid;
    assign data_wready = wready;

    assign data_bid    = bid;
    assign data_bresp  = bresp;
    assign data_bvalid = bvalid;
    assign bready      = data_bready;

endmodule

`default_nettype wire

// File: common/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // sram geometry, one 32-bit word per entry
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

    typedef logic [MEM_AW-1:0] mem_word_addr_t;

    // one burst in flight at a time
    typedef enum logic [1:0]
    {
        IDLE,
        READ,
        WRITE,
        RESP
    } sram_state_t;

endpackage

`default_nettype wire

// File: common/axi_pkg.sv
`default_nettype none

package axi_pkg;

    ////////////////////
    // field widths
    ////////////////////

    typedef logic [3:0]  axi_id_t;
    typedef logic [31:0] axi_addr_t;

    // beats in burst minus one
    typedef logic [7:0]  axi_len_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;

    ////////////////////
    // encodings
    ////////////////////

    // wrap bursts not served here
    localparam axi_burst_t BURST_FIXED = 2'd0;
    localparam axi_burst_t BURST_INCR  = 2'd1;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire
